//--- Makefile
# Verilator flow for the store queue: lint, simulate, clean

VERILATOR ?= verilator
FILELIST  ?= vlog.f
RTL_TOP   ?= stq_top
TB_TOP    ?= tb_stq
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/stq_alloc.sv
// Store queue pointers: tail, commit and head, with registered credit return
`timescale 1ns/1ns
`include "stq_params.svh"

module stq_alloc (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_disp_valid,
  input  logic                  i_flush,
  input  logic                  i_commit,
  input  logic                  i_release,
  output logic [`STQ_IDX_W-1:0] o_tail_idx,
  output logic [`STQ_IDX_W-1:0] o_cmt_idx,
  output logic [`STQ_IDX_W-1:0] o_head_idx,
  output logic [1:0]            o_credit_ret
);

  logic                  w_disp_ok;
  logic                  w_disp_drop;
  logic [`STQ_IDX_W-1:0] r_tail;
  logic [`STQ_IDX_W-1:0] r_cmt;
  logic [`STQ_IDX_W-1:0] r_head;
  logic [1:0]            r_credit;

  // A dispatch in a flush cycle is dropped and its credit handed back
  assign w_disp_ok   = i_disp_valid & ~i_flush;
  assign w_disp_drop = i_disp_valid & i_flush;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail   <= '0;
      r_cmt    <= '0;
      r_head   <= '0;
      r_credit <= '0;
    end else begin
      if (w_disp_ok) begin
        r_tail <= r_tail + 1'b1;
      end
      // Flush kills everything past the commit point
      if (i_flush) begin
        r_cmt <= r_tail;
      end else if (i_commit) begin
        r_cmt <= r_cmt + 1'b1;
      end
      if (i_release) begin
        r_head <= r_head + 1'b1;
      end
      r_credit <= {1'b0, i_release} + {1'b0, w_disp_drop};
    end
  end

  assign o_tail_idx   = r_tail;
  assign o_cmt_idx    = r_cmt;
  assign o_head_idx   = r_head;
  assign o_credit_ret = r_credit;

endmodule

//--- hw/stq_drain.sv
// In-order drain of committed stores into the store buffer output register
`timescale 1ns/1ns
`include "stq_params.svh"

module stq_drain
  import stq_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  stq_entry_t [`STQ_DEPTH-1:0] i_entries,
  input  logic [`STQ_IDX_W-1:0]       i_head_idx,
  input  logic                        i_stb_ready,
  output logic                        o_release,
  output logic                        o_stb_valid,
  output stq_stb_req_t                o_stb_req
);

  stq_entry_t           w_head;
  logic                 w_head_rdy;
  logic                 w_head_dead;
  logic                 w_reg_free;
  logic                 w_load;
  logic [`DATA_B_W-1:0] w_strb;
  logic [`DATA_W-1:0]   w_data;

  logic                 r_valid;
  stq_stb_req_t         r_req;

  // --------------------------------------------------
  // Head selection
  // --------------------------------------------------
  assign w_head      = i_entries[i_head_idx];
  assign w_head_rdy  = (w_head.state == CMT) & w_head.addr_valid & w_head.data_valid;
  assign w_head_dead = (w_head.state == DEAD);

  // Register can take a new beat when empty or being accepted
  assign w_reg_free = ~r_valid | i_stb_ready;
  assign w_load     = w_head_rdy & w_reg_free;

  // Dead head leaves without a store buffer write
  assign o_release = w_load | w_head_dead;

  // Byte lanes from size and offset
  assign w_strb = stq_strb(w_head.size, w_head.addr[`DW_OFF_W-1:0]);
  assign w_data = stq_align(w_head.data, w_head.addr[`DW_OFF_W-1:0]);

  // --------------------------------------------------
  // Store buffer output register
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      if (w_load) begin
        r_valid <= 1'b1;
      end else if (i_stb_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  // Held while ready is low
  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_req.addr <= w_head.addr[`PADDR_W-1:`DW_OFF_W];
      r_req.strb <= w_strb;
      r_req.data <= w_data;
    end
  end

  assign o_stb_valid = r_valid;
  assign o_stb_req   = r_req;

endmodule

//--- hw/stq_entry_array.sv
// Store queue entry storage with per-entry state machine and field capture
`timescale 1ns/1ns
`include "stq_params.svh"

module stq_entry_array
  import stq_pkg::*;
(
  input  logic                               i_clk,
  input  logic                               i_reset_n,
  input  logic                               i_disp_valid,
  input  logic                               i_flush,
  input  logic [`STQ_IDX_W-1:0]              i_tail_idx,
  input  logic [`STQ_IDX_W-1:0]              i_cmt_idx,
  input  logic                               i_commit,
  input  logic                               i_release,
  input  logic [`STQ_IDX_W-1:0]              i_head_idx,
  input  stq_addr_upd_t                      i_addr_upd,
  input  stq_data_upd_t                      i_data_upd,
  output stq_entry_t [`STQ_DEPTH-1:0]        o_entries
);

  logic w_disp_ok;

  assign w_disp_ok = i_disp_valid & ~i_flush;

  for (genvar s = 0; s < `STQ_DEPTH; s++) begin : g_entry
    localparam logic [`STQ_IDX_W-1:0] IDX = s;

    stq_state_e          r_state;
    logic                r_addr_valid;
    logic                r_data_valid;
    stq_size_e           r_size;
    logic [`PADDR_W-1:0] r_addr;
    logic [`DATA_W-1:0]  r_data;

    logic w_alloc;
    logic w_cmt_hit;
    logic w_rel_hit;
    logic w_addr_hit;
    logic w_data_hit;

    // Index decode for this slot
    assign w_alloc    = w_disp_ok & (i_tail_idx == IDX);
    assign w_cmt_hit  = i_commit & (i_cmt_idx == IDX);
    assign w_rel_hit  = i_release & (i_head_idx == IDX);
    assign w_addr_hit = i_addr_upd.valid & (i_addr_upd.idx == IDX);
    assign w_data_hit = i_data_upd.valid & (i_data_upd.idx == IDX);

    // ------------------------------------------------
    // Entry state
    // ------------------------------------------------
    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state      <= FREE;
        r_addr_valid <= 1'b0;
        r_data_valid <= 1'b0;
      end else begin
        case (r_state)
          FREE: begin
            if (w_alloc) begin
              r_state <= PEND;
            end
          end
          PEND: begin
            // Commit wins over a flush in the same cycle
            if (w_cmt_hit) begin
              r_state <= CMT;
            end else if (i_flush) begin
              r_state <= DEAD;
            end
          end
          CMT, DEAD: begin
            if (w_rel_hit) begin
              r_state <= FREE;
            end
          end
        endcase

        if (w_alloc) begin
          r_addr_valid <= 1'b0;
        end else if (w_addr_hit) begin
          r_addr_valid <= 1'b1;
        end

        if (w_alloc) begin
          r_data_valid <= 1'b0;
        end else if (w_data_hit) begin
          r_data_valid <= 1'b1;
        end
      end
    end

    // ------------------------------------------------
    // Payload capture
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
      if (w_addr_hit) begin
        r_addr <= i_addr_upd.addr;
        r_size <= i_addr_upd.size;
      end
      if (w_data_hit) begin
        r_data <= i_data_upd.data;
      end
    end

    assign o_entries[s] = '{state:      r_state,
                            addr_valid: r_addr_valid,
                            data_valid: r_data_valid,
                            size:       r_size,
                            addr:       r_addr,
                            data:       r_data};
  end

endmodule

//--- hw/stq_fwd.sv
// Store-to-load forwarding: per-byte youngest older store, registered answer
`timescale 1ns/1ns
`include "stq_params.svh"

module stq_fwd
  import stq_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  stq_entry_t [`STQ_DEPTH-1:0] i_entries,
  input  logic [`STQ_IDX_W-1:0]       i_head_idx,
  input  stq_fwd_req_t                i_fwd_req,
  output stq_fwd_resp_t               o_fwd_resp
);

  logic [`STQ_DEPTH-1:0] w_cand;
  logic [`DATA_B_W-1:0]  w_strb    [`STQ_DEPTH];
  logic [`DATA_W-1:0]    w_aligned [`STQ_DEPTH];
  logic [`DATA_B_W-1:0]  w_hit;
  logic [`DATA_B_W-1:0]  w_pend;
  logic [`DATA_W-1:0]    w_data;

  logic                  r_valid;
  logic [`DATA_B_W-1:0]  r_hit;
  logic                  r_hazard;
  logic [`DATA_W-1:0]    r_data;

  // Live entry with a known address in the queried doubleword
  for (genvar s = 0; s < `STQ_DEPTH; s++) begin : g_cand
    assign w_cand[s] = ((i_entries[s].state == PEND) | (i_entries[s].state == CMT)) &
                       i_entries[s].addr_valid &
                       (i_entries[s].addr[`PADDR_W-1:`DW_OFF_W] ==
                        i_fwd_req.addr[`PADDR_W-1:`DW_OFF_W]);
    assign w_strb[s]    = stq_strb(i_entries[s].size, i_entries[s].addr[`DW_OFF_W-1:0]);
    assign w_aligned[s] = stq_align(i_entries[s].data, i_entries[s].addr[`DW_OFF_W-1:0]);
  end

  // Walk oldest to youngest from the head, so the last match per byte wins
  always_comb begin
    logic [`STQ_IDX_W-1:0] idx;
    w_hit  = '0;
    w_pend = '0;
    w_data = '0;
    for (int b = 0; b < `DATA_B_W; b++) begin
      for (int k = 0; k < `STQ_DEPTH; k++) begin
        idx = i_head_idx + k[`STQ_IDX_W-1:0];
        if (w_cand[idx] & w_strb[idx][b] & i_fwd_req.mask[b]) begin
          w_hit[b]         = i_entries[idx].data_valid;
          w_pend[b]        = ~i_entries[idx].data_valid;
          w_data[b*8 +: 8] = i_entries[idx].data_valid ? w_aligned[idx][b*8 +: 8] : 8'h00;
        end
      end
    end
  end

  // --------------------------------------------------
  // Response register
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= 1'b0;
      r_hit    <= '0;
      r_hazard <= 1'b0;
    end else begin
      r_valid  <= i_fwd_req.valid;
      r_hit    <= w_hit & {`DATA_B_W{i_fwd_req.valid}};
      r_hazard <= i_fwd_req.valid & (|w_pend);
    end
  end

  always_ff @(posedge i_clk) begin
    r_data <= w_data;
  end

  assign o_fwd_resp = '{valid: r_valid, hit: r_hit, data: r_data, hazard: r_hazard};

endmodule

//--- hw/stq_params.svh
// Store queue sizing and datapath width definitions
`ifndef STQ_PARAMS_SVH
`define STQ_PARAMS_SVH

// --------------------------------------------------
// Queue geometry
// --------------------------------------------------

// Number of store queue entries
`define STQ_DEPTH 8

// Entry index width, log2 of the depth
`define STQ_IDX_W 3

// --------------------------------------------------
// Datapath
// --------------------------------------------------

`define PADDR_W 32
`define DATA_W 64

// Bytes in one data word, and the byte offset width inside it
`define DATA_B_W 8
`define DW_OFF_W 3

`endif

//--- hw/stq_pkg.sv
// Store queue types: entry state, access size, port payloads and lane helpers
`include "stq_params.svh"

package stq_pkg;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------

  // PEND waits for commit, CMT waits for drain, DEAD is flushed
  typedef enum logic [1:0] {FREE, PEND, CMT, DEAD} stq_state_e;

  typedef enum logic [1:0] {SZ_B, SZ_H, SZ_W, SZ_D} stq_size_e;

  // --------------------------------------------------
  // Entry and port payloads
  // --------------------------------------------------

  typedef struct packed {
    stq_state_e          state;
    logic                addr_valid;
    logic                data_valid;
    stq_size_e           size;
    logic [`PADDR_W-1:0] addr;
    logic [`DATA_W-1:0]  data;
  } stq_entry_t;

  typedef struct packed {
    logic                  valid;
    logic [`STQ_IDX_W-1:0] idx;
    logic [`PADDR_W-1:0]   addr;
    stq_size_e             size;
  } stq_addr_upd_t;

  typedef struct packed {
    logic                  valid;
    logic [`STQ_IDX_W-1:0] idx;
    logic [`DATA_W-1:0]    data;
  } stq_data_upd_t;

  typedef struct packed {
    logic                 valid;
    logic [`PADDR_W-1:0]  addr;
    logic [`DATA_B_W-1:0] mask;
  } stq_fwd_req_t;

  typedef struct packed {
    logic                 valid;
    logic [`DATA_B_W-1:0] hit;
    logic [`DATA_W-1:0]   data;
    logic                 hazard;
  } stq_fwd_resp_t;

  // Doubleword address, byte lanes already placed
  typedef struct packed {
    logic [`PADDR_W-`DW_OFF_W-1:0] addr;
    logic [`DATA_B_W-1:0]          strb;
    logic [`DATA_W-1:0]            data;
  } stq_stb_req_t;

  // Byte enables of an access at the given offset
  function automatic logic [`DATA_B_W-1:0] stq_strb(stq_size_e size,
                                                    logic [`DW_OFF_W-1:0] off);
    logic [`DATA_B_W-1:0] base;
    case (size)
      SZ_B: base = 8'h01;
      SZ_H: base = 8'h03;
      SZ_W: base = 8'h0f;
      SZ_D: base = 8'hff;
    endcase
    return base << off;
  endfunction

  // Move register-aligned store data to its byte lane
  function automatic logic [`DATA_W-1:0] stq_align(logic [`DATA_W-1:0] data,
                                                   logic [`DW_OFF_W-1:0] off);
    return data << {off, 3'b000};
  endfunction

endpackage

//--- hw/stq_top.sv
// Store queue top level: allocation, entry array, forwarding and drain
`timescale 1ns/1ns
`include "stq_params.svh"

module stq_top
  import stq_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  // Dispatch and credit return
  input  logic                  i_disp_valid,
  output logic [`STQ_IDX_W-1:0] o_disp_idx,
  output logic [1:0]            o_credit_ret,

  // Pipeline updates and commit
  input  stq_addr_upd_t         i_addr_upd,
  input  stq_data_upd_t         i_data_upd,
  input  logic                  i_commit,
  input  logic                  i_flush,

  // Load forwarding query
  input  stq_fwd_req_t          i_fwd_req,
  output stq_fwd_resp_t         o_fwd_resp,

  // Store buffer write
  output logic                  o_stb_valid,
  output stq_stb_req_t          o_stb_req,
  input  logic                  i_stb_ready
);

  logic [`STQ_IDX_W-1:0]       w_tail_idx;
  logic [`STQ_IDX_W-1:0]       w_cmt_idx;
  logic [`STQ_IDX_W-1:0]       w_head_idx;
  logic                        w_release;
  stq_entry_t [`STQ_DEPTH-1:0] w_entries;

  // New store goes to the tail slot
  assign o_disp_idx = w_tail_idx;

  stq_alloc u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_flush      (i_flush),
    .i_commit     (i_commit),
    .i_release    (w_release),
    .o_tail_idx   (w_tail_idx),
    .o_cmt_idx    (w_cmt_idx),
    .o_head_idx   (w_head_idx),
    .o_credit_ret (o_credit_ret)
  );

  stq_entry_array u_entry_array (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_flush      (i_flush),
    .i_tail_idx   (w_tail_idx),
    .i_cmt_idx    (w_cmt_idx),
    .i_commit     (i_commit),
    .i_release    (w_release),
    .i_head_idx   (w_head_idx),
    .i_addr_upd   (i_addr_upd),
    .i_data_upd   (i_data_upd),
    .o_entries    (w_entries)
  );

  stq_fwd u_fwd (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_entries  (w_entries),
    .i_head_idx (w_head_idx),
    .i_fwd_req  (i_fwd_req),
    .o_fwd_resp (o_fwd_resp)
  );

  stq_drain u_drain (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_entries   (w_entries),
    .i_head_idx  (w_head_idx),
    .i_stb_ready (i_stb_ready),
    .o_release   (w_release),
    .o_stb_valid (o_stb_valid),
    .o_stb_req   (o_stb_req)
  );

endmodule

//--- test/tb_clock_gen.sv
// Testbench clock and active-low reset source
`timescale 1ns/1ns

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  localparam int HALF_NS   = 20;
  localparam int RESET_CYC = 5;

  initial begin
    o_clk = 1'b0;
    forever #HALF_NS o_clk = ~o_clk;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYC) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

//--- test/tb_stq.sv
// Store queue testbench with random traffic against a reference model, forwarding and flush
`timescale 1ns/1ns
`include "stq_params.svh"

module tb_stq
  import stq_pkg::*;
();

  localparam int CLK_NS    = 40;
  localparam int N_RANDOM  = 300;
  localparam int DRAIN_MAX = 200;
  // Cycle budgets of all tests added up
  localparam int BUDGET = 20 + 2 * (N_RANDOM + DRAIN_MAX) + 100 + (DRAIN_MAX + 20) + 20;

  logic                  clk;
  logic                  reset_n;
  logic                  disp_valid;
  logic [`STQ_IDX_W-1:0] disp_idx;
  logic [1:0]            credit_ret;
  stq_addr_upd_t         addr_upd;
  stq_data_upd_t         data_upd;
  logic                  commit;
  logic                  flush;
  stq_fwd_req_t          fwd_req;
  stq_fwd_resp_t         fwd_resp;
  logic                  stb_valid;
  stq_stb_req_t          stb_req;
  logic                  stb_ready;

  tb_clock_gen u_clock_gen (.o_clk(clk), .o_reset_n(reset_n));

  stq_top i_dut (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_disp_valid (disp_valid),
    .o_disp_idx   (disp_idx),
    .o_credit_ret (credit_ret),
    .i_addr_upd   (addr_upd),
    .i_data_upd   (data_upd),
    .i_commit     (commit),
    .i_flush      (flush),
    .i_fwd_req    (fwd_req),
    .o_fwd_resp   (fwd_resp),
    .o_stb_valid  (stb_valid),
    .o_stb_req    (stb_req),
    .i_stb_ready  (stb_ready)
  );

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------
  integer                seed;
  int                    err_count;
  int                    check_count;
  int                    tests_run;
  int                    tests_failed;
  int                    test_err_start;
  int                    credits;
  int                    n_disp;
  int                    n_ret;
  logic [`STQ_IDX_W-1:0] m_tail;
  logic [`PADDR_W-1:0]   m_addr     [`STQ_DEPTH];
  stq_size_e             m_size     [`STQ_DEPTH];
  logic [`DATA_W-1:0]    m_data     [`STQ_DEPTH];
  logic                  m_has_data [`STQ_DEPTH];
  // Uncommitted slots in program order and slots still owed an update
  int                    q_uncmt[$];
  int                    q_need_addr[$];
  int                    q_need_data[$];
  // Committed slots not yet written, oldest first
  int                    q_cmt[$];
  // Writes in commit order
  stq_stb_req_t          q_exp[$];
  bit                    ready_random;
  bit                    held_prev;
  stq_stb_req_t          req_prev;
  bit                    fwd_pend;
  logic [`DATA_B_W-1:0]  exp_hit;
  logic                  exp_hazard;
  logic [`DATA_W-1:0]    exp_data;

  function automatic int rand_below(int n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  // Bytes covered by an access of this size at this offset
  function automatic logic [`DATA_B_W-1:0] lane_mask(stq_size_e size, logic [2:0] off);
    logic [`DATA_B_W-1:0] m;
    int                   o;
    int                   nbytes;
    m      = '0;
    o      = int'(off);
    nbytes = 1 << int'(size);
    for (int b = 0; b < `DATA_B_W; b++) begin
      if (b >= o && b < o + nbytes) begin
        m[b] = 1'b1;
      end
    end
    return m;
  endfunction

  // Store data placed on its byte lanes with other lanes zero
  function automatic logic [`DATA_W-1:0] lane_data(int slot);
    logic [`DATA_W-1:0]   d;
    logic [`DATA_B_W-1:0] m;
    int                   off;
    d   = '0;
    off = int'(m_addr[slot][2:0]);
    m   = lane_mask(m_size[slot], m_addr[slot][2:0]);
    for (int b = 0; b < `DATA_B_W; b++) begin
      if (m[b]) begin
        d[b*8 +: 8] = m_data[slot][(b - off)*8 +: 8];
      end
    end
    return d;
  endfunction

  function automatic logic [`DATA_W-1:0] byte_bits(logic [`DATA_B_W-1:0] m);
    logic [`DATA_W-1:0] d;
    for (int b = 0; b < `DATA_B_W; b++) begin
      d[b*8 +: 8] = {8{m[b]}};
    end
    return d;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("Error: %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
      err_count++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s at %0t ns", msg, $time);
    err_count++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == test_err_start) begin
      $display("Test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL with %0d errors", tests_run, name, err_count - test_err_start);
    end
    test_err_start = err_count;
  endtask

  // --------------------------------------------------
  // Per-cycle monitor and input defaults
  // --------------------------------------------------
  task automatic next_cycle();
    stq_stb_req_t exp_req;
    @(negedge clk);
    credits = credits + int'(credit_ret);
    n_ret   = n_ret + int'(credit_ret);
    if (credits > `STQ_DEPTH) begin
      report_failure("More credits returned than stores dispatched");
    end
    // Answer to the query of the previous cycle
    check_value("o_fwd_resp.valid", 128'(fwd_resp.valid), 128'(fwd_pend));
    if (fwd_pend) begin
      check_value("o_fwd_resp.hit", 128'(fwd_resp.hit), 128'(exp_hit));
      check_value("o_fwd_resp.hazard", 128'(fwd_resp.hazard), 128'(exp_hazard));
      check_value("o_fwd_resp.data", 128'(fwd_resp.data & byte_bits(exp_hit)), 128'(exp_data));
    end
    fwd_pend   = 1'b0;
    disp_valid = 1'b0;
    commit     = 1'b0;
    flush      = 1'b0;
    addr_upd   = '0;
    data_upd   = '0;
    fwd_req    = '0;
    stb_ready  = ready_random ? (rand_below(4) != 0) : 1'b1;
    // Store buffer handshake completes at the coming edge
    if (held_prev) begin
      if (!stb_valid) begin
        report_failure("Store buffer request withdrawn before it was accepted");
      end else begin
        check_value("o_stb_req", 128'(stb_req), 128'(req_prev));
      end
    end
    if (stb_valid && stb_ready) begin
      if (q_exp.size() == 0) begin
        report_failure("Store buffer write with no committed store left to drain");
      end else begin
        exp_req = q_exp.pop_front();
        q_cmt.delete(0);
        check_value("o_stb_req.addr", 128'(stb_req.addr), 128'(exp_req.addr));
        check_value("o_stb_req.strb", 128'(stb_req.strb), 128'(exp_req.strb));
        check_value("o_stb_req.data", 128'(stb_req.data & byte_bits(exp_req.strb)),
                    128'(exp_req.data));
      end
    end
    held_prev = stb_valid && !stb_ready;
    req_prev  = stb_req;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic dispatch_store(input bit near);
    int                  slot;
    int                  sz;
    logic [2:0]          off;
    logic [`PADDR_W-1:0] base;
    slot = int'(m_tail);
    check_value("o_disp_idx", 128'(disp_idx), 128'(m_tail));
    m_size[slot] = stq_size_e'(2'(rand_below(4)));
    sz   = int'(m_size[slot]);
    // Naturally aligned offset
    off  = 3'(rand_below(8 >> sz) << sz);
    base = near ? (32'h0000_1000 + 32'(rand_below(2) * 8)) : (32'($random(seed)) & 32'hffff_fff8);
    m_addr[slot]     = base | 32'(off);
    m_data[slot]     = {$random(seed), $random(seed)};
    m_has_data[slot] = 1'b0;
    q_uncmt.push_back(slot);
    q_need_addr.push_back(slot);
    q_need_data.push_back(slot);
    m_tail     = m_tail + 3'd1;
    credits--;
    n_disp++;
    disp_valid = 1'b1;
  endtask

  task automatic send_addr();
    int k;
    int slot;
    k    = rand_below(q_need_addr.size());
    slot = q_need_addr[k];
    q_need_addr.delete(k);
    addr_upd.valid = 1'b1;
    addr_upd.idx   = 3'(slot);
    addr_upd.addr  = m_addr[slot];
    addr_upd.size  = m_size[slot];
  endtask

  task automatic send_data();
    int k;
    int slot;
    k    = rand_below(q_need_data.size());
    slot = q_need_data[k];
    q_need_data.delete(k);
    m_has_data[slot] = 1'b1;
    data_upd.valid   = 1'b1;
    data_upd.idx     = 3'(slot);
    data_upd.data    = m_data[slot];
  endtask

  task automatic commit_oldest();
    int           slot;
    stq_stb_req_t w;
    slot   = q_uncmt.pop_front();
    w.addr = m_addr[slot][`PADDR_W-1:`DW_OFF_W];
    w.strb = lane_mask(m_size[slot], m_addr[slot][2:0]);
    w.data = lane_data(slot);
    q_exp.push_back(w);
    q_cmt.push_back(slot);
    commit = 1'b1;
  endtask

  // Youngest live store covering each byte wins
  task automatic query_random();
    int                   young;
    int                   s;
    int                   live[$];
    logic [`DATA_B_W-1:0] lm;
    logic [`DATA_W-1:0]   ld;
    fwd_req.valid = 1'b1;
    fwd_req.addr  = 32'h0000_1000 + 32'(rand_below(2) * 8) + 32'(rand_below(8));
    fwd_req.mask  = 8'(rand_below(256));
    exp_hit    = '0;
    exp_hazard = 1'b0;
    exp_data   = '0;
    // Committed stores not yet written are older than any uncommitted one
    live = q_cmt;
    foreach (q_uncmt[i]) begin
      live.push_back(q_uncmt[i]);
    end
    for (int b = 0; b < `DATA_B_W; b++) begin
      young = -1;
      foreach (live[i]) begin
        s  = live[i];
        lm = lane_mask(m_size[s], m_addr[s][2:0]);
        if (m_addr[s][`PADDR_W-1:`DW_OFF_W] == fwd_req.addr[`PADDR_W-1:`DW_OFF_W] &&
            lm[b] && fwd_req.mask[b]) begin
          young = s;
        end
      end
      if (young >= 0) begin
        if (m_has_data[young]) begin
          ld             = lane_data(young);
          exp_hit[b]     = 1'b1;
          exp_data[b*8 +: 8] = ld[b*8 +: 8];
        end else begin
          exp_hazard = 1'b1;
        end
      end
    end
    fwd_pend = 1'b1;
  endtask

  task automatic random_traffic(input bit rdy_rand);
    int i;
    ready_random = rdy_rand;
    i = 0;
    while (i < N_RANDOM || q_uncmt.size() != 0 || q_exp.size() != 0 ||
           credits != `STQ_DEPTH) begin
      if (i >= N_RANDOM + DRAIN_MAX) begin
        report_failure("Queue did not drain after random traffic");
        break;
      end
      next_cycle();
      if (q_need_addr.size() != 0 && rand_below(2) != 0) begin
        send_addr();
      end
      if (q_need_data.size() != 0 && rand_below(2) != 0) begin
        send_data();
      end
      if (q_uncmt.size() != 0 && rand_below(5) < 2) begin
        commit_oldest();
      end
      if (i < N_RANDOM && credits > 0 && rand_below(5) < 3) begin
        dispatch_store(1'b0);
      end
      i++;
    end
    ready_random = 1'b0;
  endtask

  task automatic forwarding_check();
    repeat (6) begin
      next_cycle();
      dispatch_store(1'b1);
    end
    while (q_need_addr.size() != 0) begin
      next_cycle();
      send_addr();
    end
    // Half the stores still lack data so hazards show up
    repeat (3) begin
      next_cycle();
      send_data();
    end
    // Two oldest become committed stores that still forward until drained
    repeat (2) begin
      next_cycle();
      commit_oldest();
    end
    repeat (20) begin
      next_cycle();
      query_random();
    end
    while (q_need_data.size() != 0) begin
      next_cycle();
      send_data();
    end
    repeat (20) begin
      next_cycle();
      query_random();
    end
    next_cycle();
  endtask

  task automatic flush_check();
    int i;
    next_cycle();
    commit_oldest();
    next_cycle();
    commit_oldest();
    next_cycle();
    // This dispatch is dropped by the flush
    flush      = 1'b1;
    disp_valid = 1'b1;
    credits--;
    n_disp++;
    q_uncmt.delete();
    i = 0;
    while (q_exp.size() != 0 || credits != `STQ_DEPTH) begin
      if (i >= DRAIN_MAX) begin
        report_failure("Credits of flushed stores did not return");
        break;
      end
      next_cycle();
      i++;
    end
    // A flushed store written late would show here
    repeat (10) next_cycle();
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    seed           = 76604;
    err_count      = 0;
    check_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err_start = 0;
    credits        = `STQ_DEPTH;
    n_disp         = 0;
    n_ret          = 0;
    m_tail         = '0;
    ready_random   = 1'b0;
    held_prev      = 1'b0;
    fwd_pend       = 1'b0;
    disp_valid     = 1'b0;
    commit         = 1'b0;
    flush          = 1'b0;
    addr_upd       = '0;
    data_upd       = '0;
    fwd_req        = '0;
    stb_ready      = 1'b1;

    wait (reset_n === 1'b1);
    check_value("o_stb_valid", 128'(stb_valid), 128'(0));
    check_value("o_fwd_resp.valid", 128'(fwd_resp.valid), 128'(0));
    check_value("o_credit_ret", 128'(credit_ret), 128'(0));
    end_test("reset state");

    random_traffic(1'b0);
    end_test("random traffic, store buffer always ready");
    random_traffic(1'b1);
    end_test("random traffic, store buffer back-pressure");
    forwarding_check();
    end_test("load forwarding and data hazard");
    flush_check();
    end_test("flush of uncommitted stores");
    check_value("credits_returned", 128'(n_ret), 128'(n_disp));
    check_value("credit_count", 128'(credits), 128'(`STQ_DEPTH));
    end_test("credit balance");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(BUDGET * CLK_NS);
    $display("Watchdog expired after %0d cycles, the run did not complete", BUDGET);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/stq_pkg.sv
hw/stq_alloc.sv
hw/stq_entry_array.sv
hw/stq_fwd.sv
hw/stq_drain.sv
hw/stq_top.sv
test/tb_clock_gen.sv
test/tb_stq.sv
